//--- design/bp_cfg.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes for the predictor. BTB rows and OBQ depth must be powers of two
// BP_HIST_BITS sets PHT size, so keep it small (PHT is flops)
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// Direct-mapped BTB rows
`define BP_BTB_ROWS 16

// Tag bits kept per BTB row
`define BP_TAG_BITS 8

// GHR length, PHT has 2**BP_HIST_BITS counters
`define BP_HIST_BITS 6

// In-flight branch records
`define BP_OBQ_DEPTH 8

`endif

//--- design/bp_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the predictor, sized from bp_cfg.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bp_cfg.svh"

package bp_pkg;

	// Byte address, instructions are word aligned
	typedef logic [31:0] addr_t;

	// BTB tag, bits above the row index
	typedef logic [`BP_TAG_BITS-1:0] btb_tag_t;

	// Global branch history, newest outcome in bit 0
	typedef logic [`BP_HIST_BITS-1:0] hist_t;

	// 2-bit saturating counter
	// 0,1 not taken  2,3 taken
	typedef logic [1:0] ctr_t;

	// OBQ slot index plus wrap bit
	// Wrap bit tells full from empty
	typedef logic [$clog2(`BP_OBQ_DEPTH):0] obq_idx_t;

endpackage

//--- design/btb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped BTB, combinational lookup, written only by taken retires
// Targets held as word addresses; a retire target must be word aligned
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bp_cfg.svh"

module btb import bp_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  addr_t if_pc,            // Fetch PC to look up
	input  logic  rt_en_branch,     // Retire strobe
	input  logic  rt_branch_taken,  // Actual outcome
	input  addr_t rt_pc,            // Retiring branch PC
	input  addr_t rt_calculated_pc, // Actual target
	output addr_t target_pc,
	output logic  target_hit
);

	localparam int IDX_BITS = $clog2(`BP_BTB_ROWS);
	localparam int TAG_LO   = IDX_BITS + 2;            // Tag starts above index
	localparam int TAG_HI   = TAG_LO + `BP_TAG_BITS - 1;

	logic [`BP_BTB_ROWS-1:0] valid;                 // One per row
	btb_tag_t                tag_mem [`BP_BTB_ROWS];
	logic [29:0]             tgt_mem [`BP_BTB_ROWS]; // Word target, low 2 bits dropped

	logic [IDX_BITS-1:0] if_idx;
	btb_tag_t            if_tag;
	logic [IDX_BITS-1:0] rt_idx;
	btb_tag_t            rt_tag;
	logic                wr_en;

	// Index just above the byte offset
	assign if_idx = if_pc[IDX_BITS+1:2];
	assign if_tag = if_pc[TAG_HI:TAG_LO];
	assign rt_idx = rt_pc[IDX_BITS+1:2];
	assign rt_tag = rt_pc[TAG_HI:TAG_LO];

	// Only taken branches allocate
	assign wr_en = rt_en_branch & rt_branch_taken;

	// Lookup, hit needs valid row and matching tag
	assign target_hit = valid[if_idx] && (tag_mem[if_idx] == if_tag);
	assign target_pc  = {tgt_mem[if_idx], 2'b00};

	// Valid bits
	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;     // Cold BTB
		end else if (wr_en) begin
			valid[rt_idx] <= 1'b1;
		end
	end

	// Tag and target storage
	always_ff @(posedge clock) begin
		if (wr_en) begin
			tag_mem[rt_idx] <= rt_tag;                  // Overwrites any alias
			tgt_mem[rt_idx] <= rt_calculated_pc[31:2];
		end
	end

	// Low target bits are dropped on write, so they must be zero
	a_target_aligned: assert property (
		@(posedge clock) disable iff (reset)
		wr_en |-> rt_calculated_pc[1:0] == 2'b00
	) else $error("btb: taken retire with unaligned target %h", rt_calculated_pc);

endmodule

//--- design/gshare.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Gshare direction predictor, speculative GHR repaired on a mispredict
// Training uses the history saved in the OBQ, not the live GHR
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bp_cfg.svh"

module gshare import bp_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  logic  if_branch,             // Fetch is a branch
	input  addr_t if_pc,
	input  logic  rt_en_branch,          // Retire strobe
	input  logic  rt_branch_taken,
	input  logic  rt_prediction_correct,
	input  addr_t rt_pc,
	input  hist_t head_hist,             // History used when this branch was predicted
	output logic  prediction,            // 1 = taken
	output hist_t fetch_hist             // GHR before this fetch shifts it
);

	localparam int H        = `BP_HIST_BITS;
	localparam int PHT_ROWS = 1 << H;

	hist_t ghr;
	ctr_t  pht [PHT_ROWS];

	hist_t fetch_idx;
	hist_t rt_idx;
	ctr_t  rt_ctr;
	ctr_t  rt_ctr_next;
	logic  mispredict;

	// Word bits of PC hashed with history
	assign fetch_idx = if_pc[H+1:2] ^ ghr;
	assign rt_idx    = rt_pc[H+1:2] ^ head_hist;   // Same index as at predict time

	assign prediction = pht[fetch_idx][1];         // Top bit set means taken
	assign fetch_hist = ghr;

	assign mispredict = rt_en_branch & ~rt_prediction_correct;

	// Step counter toward the actual outcome
	assign rt_ctr = pht[rt_idx];
	always_comb begin
		rt_ctr_next = rt_ctr;
		if (rt_branch_taken && rt_ctr != 2'd3) begin
			rt_ctr_next = rt_ctr + 2'd1;
		end else if (!rt_branch_taken && rt_ctr != 2'd0) begin
			rt_ctr_next = rt_ctr - 2'd1;
		end
		// Saturated counters keep their value
	end

	// PHT, trained only at retire
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < PHT_ROWS; i++) begin
				pht[i] <= 2'd1;        // Weakly not taken
			end
		end else if (rt_en_branch) begin
			pht[rt_idx] <= rt_ctr_next;
		end
	end

	// GHR
	always_ff @(posedge clock) begin
		if (reset) begin
			ghr <= '0;
		end else if (mispredict) begin
			// Repair from saved history plus real outcome
			// Wins over a same-cycle fetch, which is wrong path anyway
			ghr <= {head_hist[H-2:0], rt_branch_taken};
		end else if (if_branch) begin
			ghr <= {ghr[H-2:0], prediction};   // Speculative shift
		end
	end

endmodule

//--- design/obq.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Outstanding branch queue, in-order retire only, mispredict flushes all
// Fetch must hold off while obq_full is high
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bp_cfg.svh"

module obq import bp_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     if_branch,              // Push strobe
	input  hist_t    fetch_hist,             // History to save
	input  logic     rt_en_branch,           // Pop strobe
	input  logic     rt_prediction_correct,
	input  obq_idx_t rt_branch_index,        // Slot of the retiring branch
	output obq_idx_t push_index,             // Slot given to this fetch
	output hist_t    head_hist,
	output logic     obq_full
);

	localparam int AW = $clog2(`BP_OBQ_DEPTH);

	hist_t    hist_mem [`BP_OBQ_DEPTH];
	obq_idx_t head;            // Oldest in-flight branch
	obq_idx_t tail;            // Next free slot
	obq_idx_t head_next;
	logic     obq_empty;
	logic     mispredict;

	assign mispredict = rt_en_branch & ~rt_prediction_correct;
	assign head_next  = head + 1'b1;

	// Same slot, different lap means full
	assign obq_full  = (head[AW-1:0] == tail[AW-1:0]) && (head[AW] != tail[AW]);
	assign obq_empty = (head == tail);

	assign push_index = tail;
	assign head_hist  = hist_mem[rt_branch_index[AW-1:0]];  // Read by retire index

	// History storage
	always_ff @(posedge clock) begin
		if (if_branch) begin
			hist_mem[tail[AW-1:0]] <= fetch_hist;
		end
	end

	// Head pointer
	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
		end else if (rt_en_branch) begin
			head <= head_next;      // Pop on every retire
		end
	end

	// Tail pointer
	always_ff @(posedge clock) begin
		if (reset) begin
			tail <= '0;
		end else if (mispredict) begin
			// Flush younger entries, same-cycle push is dropped too
			tail <= head_next;
		end else if (if_branch) begin
			tail <= tail + 1'b1;
		end
	end

	// Fetch is expected to honour obq_full
	a_no_push_full: assert property (
		@(posedge clock) disable iff (reset)
		!(if_branch && obq_full)
	) else $error("obq: push while full");

	a_no_pop_empty: assert property (
		@(posedge clock) disable iff (reset)
		!(rt_en_branch && obq_empty)
	) else $error("obq: retire while empty");

	// Retire is in program order, so it always names the head
	a_retire_head: assert property (
		@(posedge clock) disable iff (reset)
		rt_en_branch |-> rt_branch_index == head
	) else $error("obq: retire index %0d, head %0d", rt_branch_index, head);

endmodule

//--- design/next_pc_select.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registered next PC, one cycle after the branch fetch; holds otherwise
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module next_pc_select import bp_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     if_branch,
	input  addr_t    if_pc,
	input  logic     prediction,      // Gshare direction
	input  logic     target_hit,      // BTB has a target
	input  addr_t    target_pc,
	input  obq_idx_t push_index,
	output logic     next_pc_valid,   // One-cycle pulse
	output addr_t    next_pc,
	output obq_idx_t next_pc_index
);

	logic  use_target;
	addr_t chosen_pc;

	// Taken needs both a taken guess and a known target
	assign use_target = prediction & target_hit;
	assign chosen_pc  = use_target ? target_pc : if_pc + 32'd4;

	always_ff @(posedge clock) begin
		if (reset) begin
			next_pc_valid <= 1'b0;
			next_pc       <= '0;
			next_pc_index <= '0;
		end else begin
			next_pc_valid <= if_branch;      // Pulse follows the strobe
			if (if_branch) begin
				next_pc       <= chosen_pc;
				next_pc_index <= push_index;   // Tag for retire
			end
		end
	end

endmodule

//--- design/branch_predictor.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch-stage predictor top: BTB, gshare, OBQ and next-PC register
// Retires must come in order and carry the index given with next_pc
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module branch_predictor import bp_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	// Fetch side
	input  logic     if_branch,
	input  addr_t    if_pc,
	// Retire side
	input  logic     rt_en_branch,
	input  logic     rt_branch_taken,
	input  logic     rt_prediction_correct,
	input  addr_t    rt_pc,
	input  addr_t    rt_calculated_pc,
	input  obq_idx_t rt_branch_index,
	// Prediction out
	output logic     next_pc_valid,
	output addr_t    next_pc,
	output obq_idx_t next_pc_index,
	output logic     obq_full
);

	addr_t    target_pc;
	logic     target_hit;
	logic     prediction;
	hist_t    fetch_hist;   // GHR before shift
	hist_t    head_hist;    // Saved history of retiring branch
	obq_idx_t push_index;

	btb u_btb (
		.clock            (clock),
		.reset            (reset),
		.if_pc            (if_pc),
		.rt_en_branch     (rt_en_branch),
		.rt_branch_taken  (rt_branch_taken),
		.rt_pc            (rt_pc),
		.rt_calculated_pc (rt_calculated_pc),
		.target_pc        (target_pc),
		.target_hit       (target_hit)
	);

	gshare u_gshare (
		.clock                 (clock),
		.reset                 (reset),
		.if_branch             (if_branch),
		.if_pc                 (if_pc),
		.rt_en_branch          (rt_en_branch),
		.rt_branch_taken       (rt_branch_taken),
		.rt_prediction_correct (rt_prediction_correct),
		.rt_pc                 (rt_pc),
		.head_hist             (head_hist),
		.prediction            (prediction),
		.fetch_hist            (fetch_hist)
	);

	obq u_obq (
		.clock                 (clock),
		.reset                 (reset),
		.if_branch             (if_branch),
		.fetch_hist            (fetch_hist),
		.rt_en_branch          (rt_en_branch),
		.rt_prediction_correct (rt_prediction_correct),
		.rt_branch_index       (rt_branch_index),
		.push_index            (push_index),
		.head_hist             (head_hist),
		.obq_full              (obq_full)
	);

	next_pc_select u_next_pc_select (
		.clock         (clock),
		.reset         (reset),
		.if_branch     (if_branch),
		.if_pc         (if_pc),
		.prediction    (prediction),
		.target_hit    (target_hit),
		.target_pc     (target_pc),
		.push_index    (push_index),
		.next_pc_valid (next_pc_valid),
		.next_pc       (next_pc),
		.next_pc_index (next_pc_index)
	);

endmodule

//--- verif/bp_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for branch_predictor that runs verif/bp_tests.txt from the project root
// Model retires in order; test file must not fetch into a full queue
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bp_cfg.svh"

module bp_tb import bp_pkg::*; ;

	localparam int MAX_TESTS    = 64;
	localparam int RESET_CYCLES = 8;
	localparam int H            = `BP_HIST_BITS;
	localparam int BW           = $clog2(`BP_BTB_ROWS);
	localparam int DEPTH        = `BP_OBQ_DEPTH;

	logic     clock;
	logic     reset;
	logic     if_branch;
	addr_t    if_pc;
	logic     rt_en_branch;
	logic     rt_branch_taken;
	logic     rt_prediction_correct;
	addr_t    rt_pc;
	addr_t    rt_calculated_pc;
	obq_idx_t rt_branch_index;
	logic     next_pc_valid;
	addr_t    next_pc;
	obq_idx_t next_pc_index;
	logic     obq_full;

	// Test table loaded once
	logic [8*24-1:0] t_name [MAX_TESTS];
	logic [7:0]      t_op [MAX_TESTS];
	addr_t           t_pc [MAX_TESTS];
	logic            t_taken [MAX_TESTS];
	addr_t           t_target [MAX_TESTS];
	int              num_tests;

	// Reference model state
	hist_t    m_ghr;
	ctr_t     m_pht [1 << H];
	logic     m_btb_valid [`BP_BTB_ROWS];
	btb_tag_t m_btb_tag [`BP_BTB_ROWS];
	addr_t    m_btb_tgt [`BP_BTB_ROWS];
	hist_t    m_hist [DEPTH];      // History used per in-flight branch
	addr_t    m_pred_pc [DEPTH];   // Next PC it was given
	obq_idx_t m_head;
	obq_idx_t m_tail;
	int       m_count;

	int cycles;
	int cycle_limit;
	int passed;
	int failed;

	branch_predictor DUT (.*);

	always #4 clock = ~clock;

	// Run limit from the test count
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, tests did not finish", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic hist_t pht_index(input addr_t pc, input hist_t hist);
		return pc[H+1:2] ^ hist;  // Word bits xor history
	endfunction

	function automatic ctr_t step_counter(input ctr_t ctr, input logic taken);
		if (taken) begin
			return (ctr == 2'd3) ? ctr : ctr + 2'd1;
		end
		return (ctr == 2'd0) ? ctr : ctr - 2'd1;
	endfunction

	task automatic load_tests();
		int              fd;
		int              n;
		string           line;
		logic [8*24-1:0] nm;
		logic [7:0]      op;
		addr_t           pc;
		int              tk;
		addr_t           tg;
		num_tests = 0;
		fd = $fopen("verif/bp_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open verif/bp_tests.txt, no tests run");
			failed++;
		end else begin
			while (!$feof(fd) && num_tests < MAX_TESTS) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%s %c %h %d %h", nm, op, pc, tk, tg);
					if (n == 5) begin
						t_name[num_tests]   = nm;
						t_op[num_tests]     = op;
						t_pc[num_tests]     = pc;
						t_taken[num_tests]  = (tk != 0);
						t_target[num_tests] = tg;
						num_tests++;
					end
				end
			end
			$fclose(fd);
			if (num_tests == 0) begin
				$display("no tests found in verif/bp_tests.txt");
				failed++;
			end
		end
	endtask

	task automatic fetch_branch(input int i, output logic ok);
		logic [BW-1:0] row;
		hist_t         idx;
		logic          pred;
		logic          hit;
		addr_t         exp_pc;
		obq_idx_t      exp_idx;
		ok = 1'b1;
		if (m_count == DEPTH) begin
			$display("%0s fetch presented while the queue is full", t_name[i]);
			ok = 1'b0;
		end else begin
			row     = t_pc[i][BW+1:2];
			idx     = pht_index(t_pc[i], m_ghr);
			pred    = m_pht[idx][1];
			hit     = m_btb_valid[row] &&
				(m_btb_tag[row] == t_pc[i][BW+2 +: `BP_TAG_BITS]);
			exp_pc  = (pred && hit) ? m_btb_tgt[row] : t_pc[i] + 32'd4;
			exp_idx = m_tail;
			if_pc     = t_pc[i];
			if_branch = 1'b1;
			@(negedge clock);
			if_branch = 1'b0;
			if (next_pc_valid !== 1'b1) begin
				$display("mismatch %0s next_pc_valid expected 1 actual %0b",
					t_name[i], next_pc_valid);
				ok = 1'b0;
			end
			if (next_pc !== exp_pc) begin
				$display("mismatch %0s next_pc expected %h actual %h", t_name[i], exp_pc, next_pc);
				ok = 1'b0;
			end
			if (next_pc_index !== exp_idx) begin
				$display("mismatch %0s next_pc_index expected %0d actual %0d",
					t_name[i], exp_idx, next_pc_index);
				ok = 1'b0;
			end
			// Push and speculative shift
			m_hist[m_tail[$clog2(DEPTH)-1:0]]    = m_ghr;
			m_pred_pc[m_tail[$clog2(DEPTH)-1:0]] = exp_pc;
			m_ghr   = {m_ghr[H-2:0], pred};
			m_tail  = m_tail + 1'b1;
			m_count = m_count + 1;
		end
	endtask

	task automatic retire_branch(input int i, output logic ok);
		int            slot;
		addr_t         actual;
		logic          correct;
		logic [BW-1:0] row;
		hist_t         idx;
		ok = 1'b1;
		if (m_count == 0) begin
			$display("%0s retire with no branch in flight", t_name[i]);
			ok = 1'b0;
		end else begin
			slot    = int'(m_head[$clog2(DEPTH)-1:0]);
			actual  = t_taken[i] ? t_target[i] : t_pc[i] + 32'd4;
			correct = (m_pred_pc[slot] == actual);
			rt_en_branch          = 1'b1;
			rt_branch_taken       = t_taken[i];
			rt_prediction_correct = correct;
			rt_pc                 = t_pc[i];
			rt_calculated_pc      = t_target[i];
			rt_branch_index       = m_head;
			@(negedge clock);
			rt_en_branch = 1'b0;
			if (next_pc_valid !== 1'b0) begin
				$display("mismatch %0s next_pc_valid expected 0 actual %0b",
					t_name[i], next_pc_valid);
				ok = 1'b0;
			end
			// Train with the saved history
			idx        = pht_index(t_pc[i], m_hist[slot]);
			m_pht[idx] = step_counter(m_pht[idx], t_taken[i]);
			if (t_taken[i]) begin
				row              = t_pc[i][BW+1:2];
				m_btb_valid[row] = 1'b1;
				m_btb_tag[row]   = t_pc[i][BW+2 +: `BP_TAG_BITS];
				m_btb_tgt[row]   = t_target[i];
			end
			m_head  = m_head + 1'b1;
			m_count = m_count - 1;
			if (!correct) begin
				m_ghr   = {m_hist[slot][H-2:0], t_taken[i]};  // Repair
				m_tail  = m_head;                             // Flush
				m_count = 0;
			end
		end
	endtask

	initial begin
		int unsigned gap;
		logic        ok;
		clock = 1'b0;
		reset = 1'b1;
		if_branch = 1'b0;
		if_pc = '0;
		rt_en_branch = 1'b0;
		rt_branch_taken = 1'b0;
		rt_prediction_correct = 1'b0;
		rt_pc = '0;
		rt_calculated_pc = '0;
		rt_branch_index = '0;
		cycles = 0;
		cycle_limit = 0;
		passed = 0;
		failed = 0;
		void'($urandom(36));
		load_tests();
		cycle_limit = num_tests * 5 + RESET_CYCLES + 20;
		m_ghr   = '0;
		m_head  = '0;
		m_tail  = '0;
		m_count = 0;
		for (int k = 0; k < (1 << H); k++) begin
			m_pht[k] = 2'd1;       // Weakly not taken
		end
		for (int k = 0; k < `BP_BTB_ROWS; k++) begin
			m_btb_valid[k] = 1'b0;
		end
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
		ok = 1'b1;
		if (next_pc_valid !== 1'b0) begin
			$display("mismatch after_reset next_pc_valid expected 0 actual %0b", next_pc_valid);
			ok = 1'b0;
		end
		if (obq_full !== 1'b0) begin
			$display("mismatch after_reset obq_full expected 0 actual %0b", obq_full);
			ok = 1'b0;
		end
		if (next_pc !== '0) begin
			$display("mismatch after_reset next_pc expected %h actual %h", 32'h0, next_pc);
			ok = 1'b0;
		end
		if (ok) begin
			$display("after_reset ok");
			passed++;
		end else begin
			$display("after_reset failed");
			failed++;
		end
		for (int i = 0; i < num_tests; i++) begin
			gap = $urandom % 3;   // Idle 0 to 2 cycles
			repeat (gap) @(negedge clock);
			if (t_op[i] == "F") begin
				fetch_branch(i, ok);
			end else begin
				retire_branch(i, ok);
			end
			if (obq_full !== (m_count == DEPTH)) begin
				$display("mismatch %0s obq_full expected %0b actual %0b",
					t_name[i], (m_count == DEPTH), obq_full);
				ok = 1'b0;
			end
			if (ok) begin
				$display("%0s ok", t_name[i]);
				passed++;
			end else begin
				$display("%0s failed", t_name[i]);
				failed++;
			end
		end
		$display("tests %0d passed %0d failed %0d", passed + failed, passed, failed);
		if (failed == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+design
design/bp_pkg.sv
design/btb.sv
design/gshare.sv
design/obq.sv
design/next_pc_select.sv
design/branch_predictor.sv
verif/bp_tb.sv

//--- Makefile
# Verilator build and run for the branch predictor testbench
# Run from the project root so the test file path resolves

VERILATOR ?= verilator
TOP       ?= bp_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/bp_tests.txt
# name op pc(hex) taken target(hex)
# op F fetches a branch at pc, op R retires the oldest in flight
cold_fetch F 00000100 0 00000000
cold_retire R 00000100 1 00000200
warm_fetch_1 F 00000100 0 00000000
warm_retire_1 R 00000100 1 00000200
warm_fetch_2 F 00000100 0 00000000
warm_retire_2 R 00000100 1 00000200
warm_fetch_3 F 00000100 0 00000000
warm_retire_3 R 00000100 1 00000200
warm_fetch_4 F 00000100 0 00000000
warm_retire_4 R 00000100 1 00000200
warm_fetch_5 F 00000100 0 00000000
warm_retire_5 R 00000100 1 00000200
hist_full_fetch F 00000100 0 00000000
hist_full_retire R 00000100 1 00000200
hit_fetch F 00000100 0 00000000
hit_retire R 00000100 1 00000200
sat_fetch F 00000100 0 00000000
sat_retire R 00000100 1 00000200
alias_fetch F 00001100 0 00000000
alias_retire R 00001100 0 00000000
sat_fetch_2 F 00000100 0 00000000
nt_retire R 00000100 0 00000000
fill_1 F 00000300 0 00000000
fill_2 F 00000304 0 00000000
fill_3 F 00000308 0 00000000
fill_4 F 0000030c 0 00000000
fill_5 F 00000310 0 00000000
fill_6 F 00000314 0 00000000
fill_7 F 00000318 0 00000000
fill_8 F 0000031c 0 00000000
drain_ok R 00000300 0 00000000
flush_retire R 00000304 1 00000400
refetch F 00000100 0 00000000
refetch_retire R 00000100 1 00000200
